/* Makefile */
TOP       ?= eeprom_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
logic/i2c_pkg.sv
logic/eeprom_pkg.sv
logic/bus_sampler.sv
logic/byte_shifter.sv
logic/eeprom_control.sv
logic/eeprom_array.sv
logic/eeprom_top.sv
tb/eeprom_assertions.sv
tb/eeprom_tb.sv

/* logic/bus_sampler.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_sampler (
    input  logic sda,
    input  logic rst,
    input  logic scl,
    input  logic data_in,
    output logic scl_rise,
    output logic scl_fall,
    output logic bit_in,
    output logic start_seen,
    output logic stop_seen
);

    logic [1:0] scl_sync;
    logic [1:0] dat_sync;
    logic       scl_q;
    logic       dat_q;

    assign bit_in = dat_q;    // aligned with the edge strobes

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            scl_sync   <= 2'b11;    // idle bus is high
            dat_sync   <= 2'b11;
            scl_q      <= 1'b1;
            dat_q      <= 1'b1;
            scl_rise   <= 1'b0;
            scl_fall   <= 1'b0;
            start_seen <= 1'b0;
            stop_seen  <= 1'b0;
        end
        else
        begin
            scl_sync   <= {scl_sync[0], scl};
            dat_sync   <= {dat_sync[0], data_in};
            scl_q      <= scl_sync[1];
            dat_q      <= dat_sync[1];
            scl_rise   <= scl_sync[1] & ~scl_q;
            scl_fall   <= ~scl_sync[1] & scl_q;
            // data edges with scl held high are bus conditions, not data
            start_seen <= scl_sync[1] & scl_q & dat_q & ~dat_sync[1];
            stop_seen  <= scl_sync[1] & scl_q & ~dat_q & dat_sync[1];
        end
    end

endmodule

`default_nettype wire

/* logic/byte_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_shifter (
    input  logic                          sda,
    input  logic                          rst,
    input  logic                          scl_rise,
    input  logic                          scl_fall,
    input  logic                          bit_in,
    input  logic                          start_seen,
    input  logic                          load_tx,
    input  logic [i2c_pkg::BYTE_BITS-1:0] tx_byte,
    input  logic                          shift_out_en,
    output logic [i2c_pkg::BYTE_BITS-1:0] rx_byte,
    output logic                          byte_done,
    output logic                          ack_bit,
    output logic                          ninth_fall,
    output logic                          drive_low
);
    import i2c_pkg::*;

    logic [3:0]           bit_cnt;     // bits seen in the current 9-bit frame
    logic [BYTE_BITS-2:0] rx_shift;
    logic [BYTE_BITS-1:0] tx_shift;

    assign rx_byte    = {rx_shift, bit_in};    // complete during the eighth rise
    assign byte_done  = scl_rise && (bit_cnt == 4'(BYTE_BITS - 1));
    assign ninth_fall = scl_fall && (bit_cnt == 4'(BYTE_BITS + 1));

    always_ff @(posedge sda)
    begin
        if (rst || start_seen || ninth_fall)
        begin
            bit_cnt <= 4'd0;
        end
        else if (scl_rise && (bit_cnt <= 4'(BYTE_BITS)))
        begin
            bit_cnt <= bit_cnt + 4'd1;
        end
    end

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            ack_bit <= 1'b1;
        end
        else if (scl_rise && (bit_cnt == 4'(BYTE_BITS)))
        begin
            ack_bit <= bit_in;    // low means the master wants more
        end
    end

    always_ff @(posedge sda)
    begin
        if (scl_rise)
        begin
            rx_shift <= {rx_shift[BYTE_BITS-3:0], bit_in};
        end
    end

    // ones shift in behind the data so the line is released after bit 0
    always_ff @(posedge sda)
    begin
        if (load_tx)
        begin
            tx_shift <= {tx_byte[BYTE_BITS-2:0], 1'b1};
        end
        else if (scl_fall)
        begin
            tx_shift <= {tx_shift[BYTE_BITS-2:0], 1'b1};
        end
    end

    always_ff @(posedge sda)
    begin
        if (rst || start_seen || !shift_out_en)
        begin
            drive_low <= 1'b0;
        end
        else if (load_tx)
        begin
            drive_low <= ~tx_byte[BYTE_BITS-1];    // msb goes out right away
        end
        else if (scl_fall)
        begin
            drive_low <= ~tx_shift[BYTE_BITS-1];
        end
    end

endmodule

`default_nettype wire

/* logic/eeprom_array.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_array #(
    parameter int ADDR_W = 11
) (
    input  logic                             sda,
    input  logic                             rst,
    input  logic                             addr_load,
    input  logic [ADDR_W-1:0]                addr_value,
    input  logic                             wr_en,
    input  logic [eeprom_pkg::WORD_BITS-1:0] wr_data,
    input  logic                             rd_en,
    input  logic                             addr_inc,
    output logic [eeprom_pkg::WORD_BITS-1:0] rd_data
);
    import eeprom_pkg::*;

    logic [WORD_BITS-1:0] mem [2**ADDR_W];
    logic [ADDR_W-1:0]    cur_addr;

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            cur_addr <= '0;
        end
        else if (addr_load)
        begin
            cur_addr <= addr_value;
        end
        else if (addr_inc)
        begin
            cur_addr <= cur_addr + 1'b1;    // wraps at the top of memory
        end
    end

    always_ff @(posedge sda)
    begin
        if (wr_en)
        begin
            mem[cur_addr] <= wr_data;
        end
        if (rd_en)
        begin
            rd_data <= mem[cur_addr];
        end
    end

endmodule

`default_nettype wire

/* logic/eeprom_control.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_control #(
    parameter int ADDR_W = 11
) (
    input  logic                             sda,
    input  logic                             rst,
    input  logic                             start_seen,
    input  logic                             stop_seen,
    input  logic                             scl_fall,
    input  logic                             byte_done,
    input  logic [i2c_pkg::BYTE_BITS-1:0]    rx_byte,
    input  logic                             ack_bit,
    input  logic                             ninth_fall,
    input  logic [eeprom_pkg::WORD_BITS-1:0] rd_data,
    output logic                             ack_drive,
    output logic                             load_tx,
    output logic [i2c_pkg::BYTE_BITS-1:0]    tx_byte,
    output logic                             shift_out_en,
    output logic                             addr_load,
    output logic [ADDR_W-1:0]                addr_value,
    output logic                             wr_en,
    output logic [eeprom_pkg::WORD_BITS-1:0] wr_data,
    output logic                             rd_en,
    output logic                             addr_inc
);
    import i2c_pkg::*;
    import eeprom_pkg::*;

    ctrl_state_t       state;
    logic              read_op;       // r/w bit of the accepted control byte
    logic [ADDR_W-1:0] block_base;    // block bits above the word address
    logic              dev_match;
    logic              acking;

    assign dev_match = (rx_byte[BYTE_BITS-1 -: 4] == DEVICE_CODE);
    assign acking    = (state == ST_CTRL_ACK) || (state == ST_ADDR_ACK) ||
                       (state == ST_WDATA_ACK);
    assign tx_byte   = rd_data;    // array output is valid with load_tx

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            state        <= ST_IDLE;
            read_op      <= 1'b0;
            ack_drive    <= 1'b0;
            shift_out_en <= 1'b0;
            load_tx      <= 1'b0;
            addr_load    <= 1'b0;
            wr_en        <= 1'b0;
            rd_en        <= 1'b0;
            addr_inc     <= 1'b0;
        end
        else
        begin
            load_tx   <= rd_en;
            addr_load <= 1'b0;
            wr_en     <= 1'b0;
            rd_en     <= 1'b0;
            addr_inc  <= 1'b0;
            if (stop_seen || start_seen)
            begin
                state        <= stop_seen ? ST_IDLE : ST_CTRL;
                ack_drive    <= 1'b0;
                shift_out_en <= 1'b0;
            end
            else
            begin
                // ack is held low from the fall after bit 8 to the ninth fall
                if (acking && ninth_fall)
                begin
                    ack_drive <= 1'b0;
                end
                else if (acking && scl_fall)
                begin
                    ack_drive <= 1'b1;
                end

                case (state)
                    ST_CTRL:
                    begin
                        if (byte_done)
                        begin
                            read_op <= rx_byte[0];
                            state   <= dev_match ? ST_CTRL_ACK : ST_IDLE;
                        end
                    end
                    ST_CTRL_ACK:
                    begin
                        if (ninth_fall && read_op)
                        begin
                            rd_en        <= 1'b1;
                            addr_inc     <= 1'b1;
                            shift_out_en <= 1'b1;
                            state        <= ST_RDATA;
                        end
                        else if (ninth_fall)
                        begin
                            state <= ST_ADDR;
                        end
                    end
                    ST_ADDR:
                    begin
                        if (byte_done)
                        begin
                            addr_load <= 1'b1;
                            state     <= ST_ADDR_ACK;
                        end
                    end
                    ST_ADDR_ACK, ST_WDATA_ACK:
                    begin
                        if (ninth_fall)
                        begin
                            state <= ST_WDATA;
                        end
                    end
                    ST_WDATA:
                    begin
                        if (byte_done)
                        begin
                            wr_en    <= 1'b1;
                            addr_inc <= 1'b1;
                            state    <= ST_WDATA_ACK;
                        end
                    end
                    ST_RDATA:
                    begin
                        if (byte_done)
                        begin
                            state <= ST_RDATA_ACK;
                        end
                    end
                    ST_RDATA_ACK:
                    begin
                        if (ninth_fall && !ack_bit)
                        begin
                            rd_en    <= 1'b1;
                            addr_inc <= 1'b1;
                            state    <= ST_RDATA;
                        end
                        else if (ninth_fall)
                        begin
                            shift_out_en <= 1'b0;    // nack, wait for stop or start
                            state        <= ST_IDLE;
                        end
                    end
                    default:
                    begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge sda)
    begin
        if (state == ST_CTRL && byte_done && !rx_byte[0])
        begin
            block_base <= ADDR_W'({rx_byte[BLOCK_BITS:1], {WORD_BITS{1'b0}}});
        end
        if (state == ST_ADDR && byte_done)
        begin
            addr_value <= block_base | ADDR_W'(rx_byte);
        end
        if (state == ST_WDATA && byte_done)
        begin
            wr_data <= rx_byte;
        end
    end

endmodule

`default_nettype wire

/* logic/eeprom_pkg.sv */
`default_nettype none

package eeprom_pkg;

    // device type code in control byte bits 7 to 4
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // width of the word address byte and of a stored word
    localparam int WORD_BITS = 8;

    // most block select bits the control byte can carry, bits 3 to 1
    localparam int BLOCK_BITS = 3;

endpackage

`default_nettype wire

/* logic/eeprom_top.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_top #(
    parameter int ADDR_W = 11
) (
    input  logic sda,
    input  logic rst,
    input  logic scl,
    input  logic data_in,
    output logic data_low
);
    import i2c_pkg::*;
    import eeprom_pkg::*;

    logic                 scl_rise;
    logic                 scl_fall;
    logic                 bit_in;
    logic                 start_seen;
    logic                 stop_seen;
    logic [BYTE_BITS-1:0] rx_byte;
    logic                 byte_done;
    logic                 ack_bit;
    logic                 ninth_fall;
    logic                 drive_low;
    logic                 ack_drive;
    logic                 load_tx;
    logic [BYTE_BITS-1:0] tx_byte;
    logic                 shift_out_en;
    logic                 addr_load;
    logic [ADDR_W-1:0]    addr_value;
    logic                 wr_en;
    logic [WORD_BITS-1:0] wr_data;
    logic                 rd_en;
    logic                 addr_inc;
    logic [WORD_BITS-1:0] rd_data;

    assign data_low = ack_drive | drive_low;    // open drain, pull low only

    bus_sampler u_sampler (
        .sda        (sda),
        .rst        (rst),
        .scl        (scl),
        .data_in    (data_in),
        .scl_rise   (scl_rise),
        .scl_fall   (scl_fall),
        .bit_in     (bit_in),
        .start_seen (start_seen),
        .stop_seen  (stop_seen)
    );

    byte_shifter u_shifter (
        .sda          (sda),
        .rst          (rst),
        .scl_rise     (scl_rise),
        .scl_fall     (scl_fall),
        .bit_in       (bit_in),
        .start_seen   (start_seen),
        .load_tx      (load_tx),
        .tx_byte      (tx_byte),
        .shift_out_en (shift_out_en),
        .rx_byte      (rx_byte),
        .byte_done    (byte_done),
        .ack_bit      (ack_bit),
        .ninth_fall   (ninth_fall),
        .drive_low    (drive_low)
    );

    eeprom_control #(
        .ADDR_W (ADDR_W)
    ) u_control (
        .sda          (sda),
        .rst          (rst),
        .start_seen   (start_seen),
        .stop_seen    (stop_seen),
        .scl_fall     (scl_fall),
        .byte_done    (byte_done),
        .rx_byte      (rx_byte),
        .ack_bit      (ack_bit),
        .ninth_fall   (ninth_fall),
        .rd_data      (rd_data),
        .ack_drive    (ack_drive),
        .load_tx      (load_tx),
        .tx_byte      (tx_byte),
        .shift_out_en (shift_out_en),
        .addr_load    (addr_load),
        .addr_value   (addr_value),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .rd_en        (rd_en),
        .addr_inc     (addr_inc)
    );

    eeprom_array #(
        .ADDR_W (ADDR_W)
    ) u_array (
        .sda        (sda),
        .rst        (rst),
        .addr_load  (addr_load),
        .addr_value (addr_value),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .addr_inc   (addr_inc),
        .rd_data    (rd_data)
    );

endmodule

`default_nettype wire

/* logic/i2c_pkg.sv */
`default_nettype none

package i2c_pkg;

    // data bits in one bus byte, the acknowledge bit follows them
    localparam int BYTE_BITS = 8;

    // control FSM states, one receive/transmit phase and one ack phase per byte
    typedef enum logic [3:0] {
        ST_IDLE      = 4'd0,    // waiting for a start
        ST_CTRL      = 4'd1,    // receiving the control byte
        ST_CTRL_ACK  = 4'd2,
        ST_ADDR      = 4'd3,    // receiving the word address
        ST_ADDR_ACK  = 4'd4,
        ST_WDATA     = 4'd5,
        ST_WDATA_ACK = 4'd6,
        ST_RDATA     = 4'd7,    // shifting a data byte out
        ST_RDATA_ACK = 4'd8     // master ack or nack
    } ctrl_state_t;

endpackage

`default_nettype wire

/* tb/eeprom_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_assertions (
    input logic                 sda,
    input logic                 rst,
    input logic                 scl,
    input logic                 data_low,
    input logic                 wr_en,
    input logic                 rd_en,
    input i2c_pkg::ctrl_state_t state
);
    import i2c_pkg::*;

    logic [1:0] scl_sync;    // same two stages as the sampler

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            scl_sync <= 2'b11;
        end
        else
        begin
            scl_sync <= {scl_sync[0], scl};
        end
    end

    data_low_scl_low: assert property (@(posedge sda) disable iff (rst)
        $changed(data_low) |-> !scl_sync[1])
        else $error("data_low changed while the synchronized scl was high");

    idle_released: assert property (@(posedge sda) disable iff (rst)
        (state == ST_IDLE) |-> !data_low)
        else $error("data_low pulled low in the idle state");

    no_rd_wr_overlap: assert property (@(posedge sda) disable iff (rst)
        !(wr_en && rd_en))
        else $error("memory write and read strobes high in the same cycle");

endmodule

bind eeprom_top eeprom_assertions u_assertions (
    .sda      (sda),
    .rst      (rst),
    .scl      (scl),
    .data_low (data_low),
    .wr_en    (wr_en),
    .rd_en    (rd_en),
    .state    (u_control.state)
);

`default_nettype wire

/* tb/eeprom_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_tb;
    import eeprom_pkg::*;

    localparam int ADDR_W          = 11;
    localparam int DEPTH           = 2 ** ADDR_W;
    localparam int HALF            = 16;    // sda cycles per scl half period
    localparam int PLAN_BYTES      = 82;
    localparam int WATCHDOG_CYCLES = PLAN_BYTES * 9 * 2 * HALF + 10000;

    logic sda;
    logic rst;
    logic scl;
    logic master_low;    // master pulls the data line low
    logic data_in;
    logic data_low;

    logic [7:0] ref_mem [DEPTH];
    int         ref_cur = 0;       // expected current address
    logic [2:0] ref_block = '0;
    bit         ref_sel = 1'b0;    // slave selected by the last control byte
    int         err_count = 0;
    int         check_count = 0;
    string      what_q[$];
    logic [7:0] exp_q[$];
    logic [7:0] got_q[$];

    assign data_in = ~(master_low | data_low);    // pulled-up open drain line

    eeprom_top #(
        .ADDR_W (ADDR_W)
    ) dut0 (
        .sda      (sda),
        .rst      (rst),
        .scl      (scl),
        .data_in  (data_in),
        .data_low (data_low)
    );

    initial
    begin
        sda = 1'b0;
        forever #5 sda = ~sda;
    end

    function automatic bit ref_control(input logic [7:0] ctrl);
        ref_sel = (ctrl[7:4] == DEVICE_CODE);
        if (ref_sel && !ctrl[0])
        begin
            ref_block = ctrl[3:1];    // block bits only on a write
        end
        return ref_sel;
    endfunction

    function automatic void ref_address(input logic [7:0] word);
        if (ref_sel)
        begin
            ref_cur = ((int'(ref_block) << 8) | int'(word)) % DEPTH;
        end
    endfunction

    function automatic void ref_write(input logic [7:0] d);
        if (ref_sel)
        begin
            ref_mem[ref_cur] = d;
            ref_cur = (ref_cur + 1) % DEPTH;
        end
    endfunction

    function automatic logic [7:0] ref_read();
        logic [7:0] d;
        d = ref_mem[ref_cur];
        ref_cur = (ref_cur + 1) % DEPTH;
        return d;
    endfunction

    function automatic logic [7:0] ctrl_byte(input logic [3:0] code, input int addr,
                                             input bit rd);
        return {code, 3'(addr >> 8), rd};
    endfunction

    task automatic wait_sda(input int n);
        repeat (n) @(negedge sda);
    endtask

    task automatic expect_value(input string name, input logic [7:0] exp,
                                input logic [7:0] got);
        what_q.push_back(name);
        exp_q.push_back(exp);
        got_q.push_back(got);
    endtask

    task automatic check_quiet(input int n);
        repeat (n)
        begin
            wait_sda(1);
            expect_value("data_low", 8'h00, 8'(data_low));
        end
    endtask

    task automatic fill_random(input int n, output logic [7:0] q[$]);
        q = {};
        repeat (n) q.push_back(8'($urandom));
    endtask

    task automatic bus_start();
        wait_sda(2);
        master_low = 1'b0;
        wait_sda(HALF - 2);
        scl = 1'b1;
        wait_sda(HALF);
        master_low = 1'b1;    // data falls with scl high
        wait_sda(HALF);
        scl = 1'b0;
    endtask

    task automatic bus_stop();
        wait_sda(2);
        master_low = 1'b1;
        wait_sda(HALF - 2);
        scl = 1'b1;
        wait_sda(HALF);
        master_low = 1'b0;    // data rises with scl high
        wait_sda(HALF);
    endtask

    task automatic send_bit(input logic b);
        wait_sda(2);
        master_low = ~b;
        wait_sda(HALF - 2);
        scl = 1'b1;
        wait_sda(HALF);
        scl = 1'b0;
    endtask

    task automatic write_byte(input logic [7:0] b, output logic acked);
        for (int i = 7; i >= 0; i--)
        begin
            send_bit(b[i]);
        end
        wait_sda(2);
        master_low = 1'b0;    // slave owns the ninth bit
        wait_sda(HALF - 2);
        scl = 1'b1;
        wait_sda(HALF / 2);
        acked = ~data_in;
        wait_sda(HALF / 2);
        scl = 1'b0;
    endtask

    task automatic read_byte(input bit more, output logic [7:0] b);
        wait_sda(2);
        master_low = 1'b0;
        for (int i = 7; i >= 0; i--)
        begin
            wait_sda(i == 7 ? HALF - 2 : HALF);
            scl = 1'b1;
            wait_sda(HALF / 2);
            b[i] = data_in;
            wait_sda(HALF / 2);
            scl = 1'b0;
        end
        wait_sda(2);
        master_low = more;    // ack asks for the next byte
        wait_sda(HALF - 2);
        scl = 1'b1;
        wait_sda(HALF);
        scl = 1'b0;
    endtask

    task automatic send_control(input logic [7:0] ctrl);
        logic acked;
        bus_start();
        write_byte(ctrl, acked);
        expect_value("data_in ack", 8'(ref_control(ctrl)), 8'(acked));
    endtask

    task automatic send_address(input logic [7:0] word);
        logic acked;
        write_byte(word, acked);
        expect_value("data_in ack", 8'(ref_sel), 8'(acked));
        ref_address(word);
    endtask

    task automatic send_data(input logic [7:0] d);
        logic acked;
        write_byte(d, acked);
        expect_value("data_in ack", 8'(ref_sel), 8'(acked));
        ref_write(d);
    endtask

    task automatic read_bytes(input int n);
        logic [7:0] b;
        for (int i = 0; i < n; i++)
        begin
            read_byte(i < n - 1, b);
            expect_value("data_in read byte", ref_read(), b);
        end
        check_quiet(HALF);    // slave stays off the line after the nack
    endtask

    task automatic write_mem(input int addr, input logic [7:0] data[$]);
        send_control(ctrl_byte(DEVICE_CODE, addr, 1'b0));
        send_address(8'(addr));
        foreach (data[i])
        begin
            send_data(data[i]);
        end
        bus_stop();
    endtask

    task automatic random_read(input int addr, input int n);
        send_control(ctrl_byte(DEVICE_CODE, addr, 1'b0));
        send_address(8'(addr));
        send_control(ctrl_byte(DEVICE_CODE, addr, 1'b1));    // repeated start
        read_bytes(n);
        bus_stop();
    endtask

    task automatic current_read(input int n);
        send_control(ctrl_byte(DEVICE_CODE, 0, 1'b1));
        read_bytes(n);
        bus_stop();
    endtask

    task automatic bad_write(input int addr, input logic [7:0] d);
        send_control(ctrl_byte(4'b1011, addr, 1'b0));
        send_address(8'(addr));
        send_data(d);
        bus_stop();
    endtask

    task automatic cut_write(input int addr, input logic [7:0] d, input int nbits);
        send_control(ctrl_byte(DEVICE_CODE, addr, 1'b0));
        send_address(8'(addr));
        for (int i = 0; i < nbits; i++)
        begin
            send_bit(d[7 - i]);
        end
        bus_stop();
    endtask

    initial
    begin
        string      name;
        logic [7:0] exp;
        logic [7:0] got;
        forever
        begin
            @(posedge sda);
            while (got_q.size() != 0)
            begin
                name = what_q.pop_front();
                exp  = exp_q.pop_front();
                got  = got_q.pop_front();
                check_count++;
                assert (got === exp)
                else
                begin
                    err_count++;
                    $display("MISMATCH %s: expected 0x%h, got 0x%h", name, exp, got);
                    $display("Test failures found");
                    $fatal(1, "stopped at the first mismatch");
                end
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge sda);
        $display("timeout: bus transactions did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        logic [7:0] data[$];
        int         addr;
        void'($urandom(32'hc325a3e6));
        rst        = 1'b1;
        scl        = 1'b1;
        master_low = 1'b0;
        addr       = 0;
        repeat (10) @(negedge sda);
        rst = 1'b0;

        check_quiet(4 * HALF);    // idle after reset

        repeat (3)
        begin
            addr = $urandom_range(DEPTH - 1);
            fill_random(1, data);
            write_mem(addr, data);
            random_read(addr, 1);
        end

        // foreign device code, nothing may change
        bad_write(addr, ~data[0]);
        random_read(addr, 1);

        addr = $urandom_range(DEPTH - 16);
        fill_random(6, data);
        write_mem(addr, data);
        random_read(addr, 6);

        fill_random(3, data);
        write_mem(addr, data);
        current_read(1);    // byte after the last one written

        fill_random(4, data);
        write_mem(DEPTH - 2, data);
        random_read(DEPTH - 2, 4);

        // stop inside a data byte
        addr = $urandom_range(DEPTH - 1);
        fill_random(1, data);
        write_mem(addr, data);
        cut_write(addr, ~data[0], 4);
        random_read(addr, 1);
        fill_random(1, data);
        write_mem(addr, data);
        random_read(addr, 1);

        wait_sda(2);
        while (got_q.size() != 0)
        begin
            wait_sda(1);
        end
        if (err_count == 0 && check_count > 0)
        begin
            $display("All tests passed!");
            $finish;
        end
        else
        begin
            $display("Test failures found");
            $fatal(1, "%0d of %0d checks failed", err_count, check_count);
        end
    end

endmodule

`default_nettype wire
